/* arena_draw.f */
+incdir+verification
src/arena_geom_pkg.sv
src/arena_tile_pkg.sv
src/map_pos_if.sv
src/frame_anim_ctrl.sv
src/map_locator.sv
src/player_marker.sv
src/tile_shader.sv
src/pixel_mixer.sv
src/arena_draw.sv
verification/arena_draw_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
  -f arena_draw.f --top-module arena_draw_tb -Mdir obj_dir -o arena_draw_sim &&
{ sim_out=$(./obj_dir/arena_draw_sim 2>&1); printf '%s\n' "$sim_out";
  printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; } &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verification/arena_draw_checks.svh */
`ifndef ARENA_DRAW_CHECKS_SVH
`define ARENA_DRAW_CHECKS_SVH

// ----------------------------------------------------------
// reference model of the drawing rules
// ----------------------------------------------------------
function automatic bit coord_in_map(int x, int y);
  return (x >= HUD_SIDE) && (x < SCREEN_W - HUD_SIDE) && (y >= HUD_TOP) && (y < SCREEN_H);
endfunction

function automatic int model_addr(int x, int y);
  if (!coord_in_map(x, y)) begin
    return 0;  // memory sees 0 over the frame
  end
  return ((y - HUD_TOP) / BLK_H) * NUM_COL + (x - HUD_SIDE) / BLK_W;
endfunction

function automatic logic [RGB_W-1:0] model_rgb(int x, int y, int px, int py, dir_t dir,
                                               bit expl, int eaddr, int ticks);
  int addr;
  int ox;
  int oy;
  bit blast;
  if (!coord_in_map(x, y)) begin
    return HUD_RGB;
  end
  // player box sits above every tile kind
  if ((x >= px) && (x < px + SPRITE_W) && (y >= py) && (y < py + SPRITE_H)) begin
    case (dir)
      DIR_UP:    return (y - py < MARKER_W) ? MARKER_RGB : PLAYER_RGB;
      DIR_DOWN:  return (y - py >= SPRITE_H - MARKER_W) ? MARKER_RGB : PLAYER_RGB;
      DIR_LEFT:  return (x - px < MARKER_W) ? MARKER_RGB : PLAYER_RGB;
      DIR_RIGHT: return (x - px >= SPRITE_W - MARKER_W) ? MARKER_RGB : PLAYER_RGB;
      default:   return PLAYER_RGB;
    endcase
  end
  addr  = model_addr(x, y);
  ox    = (x - HUD_SIDE) % BLK_W;
  oy    = (y - HUD_TOP) % BLK_H;
  blast = expl && ((addr == eaddr) || (addr == eaddr - 1) || (addr == eaddr + 1) ||
                   (addr == eaddr - NUM_COL) || (addr == eaddr + NUM_COL));
  case (map_mem[addr])
    PERM_BLK: begin
      if ((ox < RIM_W) || (ox >= BLK_W - RIM_W) || (oy < RIM_W) || (oy >= BLK_H - RIM_W)) begin
        return PERM_RIM_RGB;
      end
      return PERM_RGB;
    end
    DESTROYABLE_BLK: return blast ? EXPL_RGB : BRICK_RGB;
    BOMB: begin
      if ((ox < BOMB_INSET) || (ox >= BLK_W - BOMB_INSET) ||
          (oy < BOMB_INSET) || (oy >= BLK_H - BOMB_INSET)) begin
        return BG_RGB;
      end
      return ((ticks % BOMB_CYCLE_TICKS) >= BOMB_DARK_TICKS) ? BOMB_RED_RGB : BOMB_RGB;
    end
    default: return blast ? EXPL_RGB : BG_RGB;  // floor
  endcase
endfunction

// ----------------------------------------------------------
// compare tasks
// ----------------------------------------------------------
task automatic check_addr(string name, logic [MAP_ADDR_W-1:0] exp_addr,
                          logic [MAP_ADDR_W-1:0] act_addr);
  if (act_addr !== exp_addr) begin
    $display("CHECK FAILED %s map address expected %0d actual %0d", name, exp_addr, act_addr);
    $display("=== FAIL ===");
    $fatal(1, "map address mismatch");
  end
endtask

task automatic check_rgb(string name, logic [RGB_W-1:0] exp_rgb,
                         logic [3:0] r, logic [3:0] g, logic [3:0] b);
  if ({r, g, b} !== exp_rgb) begin
    $display("CHECK FAILED %s color expected %03h actual %03h", name, exp_rgb, {r, g, b});
    $display("=== FAIL ===");
    $fatal(1, "pixel color mismatch");
  end
endtask

`endif

/* verification/arena_draw_tb.sv */
`timescale 1ns/10ps

module arena_draw_tb
  import arena_geom_pkg::*;
  import arena_tile_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 8;
  localparam int SWEEP_COUNT = 300;

  typedef struct packed {
    logic [X_W-1:0]        x;
    logic [Y_W-1:0]        y;
    logic [X_W-1:0]        px;
    logic [Y_W-1:0]        py;
    dir_t                  dir;
    logic                  expl;
    logic [MAP_ADDR_W-1:0] eaddr;
    logic [7:0]            ticks;   // ticks issued before the pixel
  } stim_t;

  logic                  clk;
  logic                  rst;
  logic                  i_tick;
  logic [X_W-1:0]        i_draw_x;
  logic [Y_W-1:0]        i_draw_y;
  logic [STATE_W-1:0]    i_map_tile_state;
  logic [X_W-1:0]        i_player_x;
  logic [Y_W-1:0]        i_player_y;
  logic [DIR_W-1:0]      i_player_dir;
  logic                  i_explode;
  logic [MAP_ADDR_W-1:0] i_expl_addr;
  logic [3:0]            o_r;
  logic [3:0]            o_g;
  logic [3:0]            o_b;
  logic [MAP_ADDR_W-1:0] o_map_addr;

  map_state_t       map_mem [MAP_DEPTH];
  stim_t            stim_q [$];
  string            name_q [$];
  int               total_ticks;
  bit               table_ready;
  int               tick_count;    // ticks seen by the DUT since reset
  bit               pend_valid;    // a color is due after the next edge
  string            pend_name;
  logic [RGB_W-1:0] pend_rgb;

  `include "arena_draw_checks.svh"

  arena_draw arena_draw_inst (.*);

  assign i_map_tile_state = map_mem[o_map_addr];  // memory answers in the same cycle

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // map layout and stimulus table
  // ----------------------------------------------------------
  function automatic void load_map();
    int row;
    int col;
    for (int a = 0; a < MAP_DEPTH; a++) begin
      row = a / NUM_COL;
      col = a % NUM_COL;
      if ((row % 2 == 1) && (col % 2 == 1)) begin
        map_mem[a] = PERM_BLK;   // pillar grid
      end else if ((row + col) % 4 == 2) begin
        map_mem[a] = DESTROYABLE_BLK;
      end else begin
        map_mem[a] = NO_BLK;
      end
    end
    map_mem[44] = BOMB;          // row 2, column 6
  endfunction

  function automatic void add_test(string name, int x, int y, int px, int py, dir_t dir,
                                   bit expl, int eaddr, int ticks);
    stim_q.push_back(stim_t'{X_W'(x), Y_W'(y), X_W'(px), Y_W'(py), dir, expl,
                             MAP_ADDR_W'(eaddr), 8'(ticks)});
    name_q.push_back(name);
    total_ticks += ticks;
  endfunction

  function automatic void fill_table();
    add_test("hud_left",      10,   300, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("hud_top",       600,  50,  0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("hud_right",     1248, 400, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("map_last",      1247, 799, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("floor",         40,   100, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("brick",         192,  128, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("perm_rim",      97,   190, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("perm_center",   128,  192, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    // cross around address 61, then around 82
    add_test("expl_center",   320,  320, 0,   0,   DIR_NONE,  1'b1, 61, 0);
    add_test("expl_up",       320,  256, 0,   0,   DIR_NONE,  1'b1, 61, 0);
    add_test("expl_down",     320,  384, 0,   0,   DIR_NONE,  1'b1, 61, 0);
    add_test("expl_left",     256,  320, 0,   0,   DIR_NONE,  1'b1, 61, 0);
    add_test("expl_diag",     384,  256, 0,   0,   DIR_NONE,  1'b1, 61, 0);
    add_test("expl_off",      320,  320, 0,   0,   DIR_NONE,  1'b0, 61, 0);
    add_test("expl2_left",    384,  384, 0,   0,   DIR_NONE,  1'b1, 82, 0);
    add_test("expl2_right",   512,  384, 0,   0,   DIR_NONE,  1'b1, 82, 0);
    add_test("bomb_dark119",  436,  244, 0,   0,   DIR_NONE,  1'b0, 0,  119);
    add_test("bomb_red120",   436,  244, 0,   0,   DIR_NONE,  1'b0, 0,  1);
    add_test("bomb_out_red",  421,  229, 0,   0,   DIR_NONE,  1'b0, 0,  0);
    add_test("bomb_red179",   436,  244, 0,   0,   DIR_NONE,  1'b0, 0,  59);
    add_test("bomb_wrap",     436,  244, 0,   0,   DIR_NONE,  1'b0, 0,  1);
    // player parked over the bomb tile
    add_test("player_body",   440,  240, 420, 220, DIR_RIGHT, 1'b0, 0,  0);
    add_test("player_right",  450,  240, 420, 220, DIR_RIGHT, 1'b0, 0,  0);
    add_test("player_up",     430,  221, 420, 220, DIR_UP,    1'b0, 0,  0);
    add_test("player_down",   430,  265, 420, 220, DIR_DOWN,  1'b0, 0,  0);
    add_test("player_left",   421,  240, 420, 220, DIR_LEFT,  1'b0, 0,  0);
    add_test("player_none",   421,  221, 420, 220, DIR_NONE,  1'b0, 0,  0);
    add_test("player_hud",    15,   301, 10,  300, DIR_UP,    1'b0, 0,  0);
  endfunction

  // ----------------------------------------------------------
  // one pixel per cycle, color checked after the next edge
  // ----------------------------------------------------------
  task automatic present_pixel(string name, stim_t s, bit tick);
    logic [RGB_W-1:0] exp_rgb;
    @(posedge clk);
    #1;
    if (pend_valid) begin
      check_rgb(pend_name, pend_rgb, o_r, o_g, o_b);
    end
    i_draw_x     = s.x;
    i_draw_y     = s.y;
    i_player_x   = s.px;
    i_player_y   = s.py;
    i_player_dir = s.dir;
    i_explode    = s.expl;
    i_expl_addr  = s.eaddr;
    i_tick       = tick;
    // this tick lands on the same edge that registers the color
    exp_rgb = model_rgb(int'(s.x), int'(s.y), int'(s.px), int'(s.py), s.dir, s.expl,
                        int'(s.eaddr), tick_count);
    #1;
    check_addr(name, MAP_ADDR_W'(model_addr(int'(s.x), int'(s.y))), o_map_addr);
    pend_valid = 1'b1;
    pend_name  = name;
    pend_rgb   = exp_rgb;
    tick_count += int'(tick);
  endtask

  task automatic flush_pending();
    @(posedge clk);
    #1;
    if (pend_valid) begin
      check_rgb(pend_name, pend_rgb, o_r, o_g, o_b);
    end
    pend_valid = 1'b0;
  endtask

  initial begin
    stim_t s;
    int    rx;
    int    ry;
    void'($urandom(90));
    rst          = 1'b1;
    i_tick       = 1'b0;
    i_draw_x     = '0;
    i_draw_y     = '0;
    i_player_x   = '0;
    i_player_y   = '0;
    i_player_dir = DIR_NONE;
    i_explode    = 1'b0;
    i_expl_addr  = '0;
    load_map();
    fill_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    check_rgb("reset", '0, o_r, o_g, o_b);
    rst = 1'b0;
    foreach (stim_q[i]) begin
      repeat (stim_q[i].ticks) present_pixel(name_q[i], stim_q[i], 1'b1);
      present_pixel(name_q[i], stim_q[i], 1'b0);
    end
    // random sweep, player dropped near the pixel so it gets hit often
    for (int n = 0; n < SWEEP_COUNT; n++) begin
      rx      = int'($urandom_range(SCREEN_W - 1, 0));
      ry      = int'($urandom_range(SCREEN_H - 1, 0));
      s.x     = X_W'(rx);
      s.y     = Y_W'(ry);
      s.px    = X_W'((rx < 40) ? 0 : rx - int'($urandom_range(40, 0)));
      s.py    = Y_W'((ry < 56) ? 0 : ry - int'($urandom_range(56, 0)));
      s.dir   = dir_t'(DIR_W'($urandom_range(4, 0)));
      s.expl  = 1'($urandom_range(1, 0));
      s.eaddr = MAP_ADDR_W'($urandom_range(MAP_DEPTH - 1, 0));
      s.ticks = '0;
      present_pixel($sformatf("sweep_%0d", n), s, 1'($urandom_range(1, 0)));
    end
    flush_pending();
    $display("=== PASS ===");
    $finish;
  end

  initial begin : watchdog
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(stim_q.size() + SWEEP_COUNT + total_ticks + RST_CYCLES) *
               3 * CLK_PERIOD + 200;
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

endmodule

/* src/arena_draw.sv */
`timescale 1ns/10ps

module arena_draw
  import arena_geom_pkg::*;
  import arena_tile_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_tick,
  input  logic [X_W-1:0]        i_draw_x,
  input  logic [Y_W-1:0]        i_draw_y,
  input  logic [STATE_W-1:0]    i_map_tile_state,
  input  logic [X_W-1:0]        i_player_x,
  input  logic [Y_W-1:0]        i_player_y,
  input  logic [DIR_W-1:0]      i_player_dir,
  input  logic                  i_explode,
  input  logic [MAP_ADDR_W-1:0] i_expl_addr,
  output logic [3:0]            o_r,
  output logic [3:0]            o_g,
  output logic [3:0]            o_b,
  output logic [MAP_ADDR_W-1:0] o_map_addr
);

  logic             bomb_red;
  logic             player_hit;
  logic [RGB_W-1:0] player_rgb;
  logic [RGB_W-1:0] tile_rgb;

  map_pos_if pos_if ();   // decoded position shared by shader and mixer

  frame_anim_ctrl frame_anim_ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .i_tick     (i_tick),
    .o_bomb_red (bomb_red)
  );

  map_locator map_locator_inst (
    .i_draw_x   (i_draw_x),
    .i_draw_y   (i_draw_y),
    .o_map_addr (o_map_addr),
    .pos        (pos_if.locator)
  );

  player_marker player_marker_inst (
    .i_draw_x     (i_draw_x),
    .i_draw_y     (i_draw_y),
    .i_player_x   (i_player_x),
    .i_player_y   (i_player_y),
    .i_player_dir (i_player_dir),
    .o_player_hit (player_hit),
    .o_player_rgb (player_rgb)
  );

  tile_shader tile_shader_inst (
    .i_map_tile_state (i_map_tile_state),
    .i_explode        (i_explode),
    .i_expl_addr      (i_expl_addr),
    .i_bomb_red       (bomb_red),
    .pos              (pos_if.consumer),
    .o_tile_rgb       (tile_rgb)
  );

  pixel_mixer pixel_mixer_inst (
    .clk          (clk),
    .rst          (rst),
    .i_player_hit (player_hit),
    .i_player_rgb (player_rgb),
    .i_tile_rgb   (tile_rgb),
    .pos          (pos_if.consumer),
    .o_r          (o_r),
    .o_g          (o_g),
    .o_b          (o_b)
  );

endmodule

/* src/pixel_mixer.sv */
`timescale 1ns/10ps

module pixel_mixer import arena_tile_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_player_hit,
  input  logic [RGB_W-1:0] i_player_rgb,
  input  logic [RGB_W-1:0] i_tile_rgb,
  map_pos_if.consumer      pos,
  output logic [3:0]       o_r,
  output logic [3:0]       o_g,
  output logic [3:0]       o_b
);

  logic [RGB_W-1:0] mix_rgb;
  logic [RGB_W-1:0] rgb_q;

  // ----------------------------------------------------------
  // priority HUD over player over tile
  // ----------------------------------------------------------
  always_comb begin
    if (!pos.in_map) begin
      mix_rgb = HUD_RGB;        // player never shows over the frame
    end else if (i_player_hit) begin
      mix_rgb = i_player_rgb;
    end else begin
      mix_rgb = i_tile_rgb;
    end
  end

  // single output stage, one pixel of latency
  always_ff @(posedge clk) begin
    if (rst) begin
      rgb_q <= '0;
    end else begin
      rgb_q <= mix_rgb;
    end
  end

  assign o_r = rgb_q[RGB_W-1 -: 4];
  assign o_g = rgb_q[7:4];
  assign o_b = rgb_q[3:0];

  // an undriven map memory or player input would surface here as X
  a_no_x_out: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown({o_r, o_g, o_b})
  ) else $error("unknown value on color output");

endmodule

/* src/tile_shader.sv */
`timescale 1ns/10ps

module tile_shader
  import arena_geom_pkg::*;
  import arena_tile_pkg::*;
(
  input  logic [STATE_W-1:0]    i_map_tile_state,
  input  logic                  i_explode,
  input  logic [MAP_ADDR_W-1:0] i_expl_addr,
  input  logic                  i_bomb_red,
  map_pos_if.consumer           pos,
  output logic [RGB_W-1:0]      o_tile_rgb
);

  map_state_t            state;
  logic [MAP_ADDR_W-1:0] up_addr;
  logic [MAP_ADDR_W-1:0] down_addr;
  logic [MAP_ADDR_W-1:0] left_addr;
  logic [MAP_ADDR_W-1:0] right_addr;
  logic                  blast_hit;
  logic                  on_rim;
  logic                  in_bomb;

  assign state = map_state_t'(i_map_tile_state);

  // ----------------------------------------------------------
  // explosion cross
  // ----------------------------------------------------------
  // neighbours by address only, row ends are not special
  assign up_addr    = i_expl_addr - MAP_ADDR_W'(NUM_COL);
  assign down_addr  = i_expl_addr + MAP_ADDR_W'(NUM_COL);
  assign left_addr  = i_expl_addr - MAP_ADDR_W'(1);
  assign right_addr = i_expl_addr + MAP_ADDR_W'(1);

  assign blast_hit = i_explode &&
                     ((pos.map_addr == i_expl_addr) ||
                      (pos.map_addr == up_addr)     ||
                      (pos.map_addr == down_addr)   ||
                      (pos.map_addr == left_addr)   ||
                      (pos.map_addr == right_addr));

  // ----------------------------------------------------------
  // in-tile shapes
  // ----------------------------------------------------------
  assign on_rim = (pos.blk_x <  BLK_W_LOG2'(RIM_W))         ||
                  (pos.blk_x >= BLK_W_LOG2'(BLK_W - RIM_W)) ||
                  (pos.blk_y <  BLK_H_LOG2'(RIM_W))         ||
                  (pos.blk_y >= BLK_H_LOG2'(BLK_H - RIM_W));

  assign in_bomb = (pos.blk_x >= BLK_W_LOG2'(BOMB_INSET))         &&
                   (pos.blk_x <  BLK_W_LOG2'(BLK_W - BOMB_INSET)) &&
                   (pos.blk_y >= BLK_H_LOG2'(BOMB_INSET))         &&
                   (pos.blk_y <  BLK_H_LOG2'(BLK_H - BOMB_INSET));

  always_comb begin
    o_tile_rgb = BG_RGB;
    unique case (state)
      NO_BLK: begin
        o_tile_rgb = blast_hit ? EXPL_RGB : BG_RGB;
      end
      DESTROYABLE_BLK: begin
        o_tile_rgb = blast_hit ? EXPL_RGB : BRICK_RGB;
      end
      PERM_BLK: begin
        o_tile_rgb = on_rim ? PERM_RIM_RGB : PERM_RGB;  // bevel
      end
      BOMB: begin
        if (in_bomb) begin
          o_tile_rgb = i_bomb_red ? BOMB_RED_RGB : BOMB_RGB;
        end else begin
          o_tile_rgb = BG_RGB;
        end
      end
    endcase
  end

endmodule

/* src/player_marker.sv */
`timescale 1ns/10ps

module player_marker
  import arena_geom_pkg::*;
  import arena_tile_pkg::*;
(
  input  logic [X_W-1:0]   i_draw_x,
  input  logic [Y_W-1:0]   i_draw_y,
  input  logic [X_W-1:0]   i_player_x,
  input  logic [Y_W-1:0]   i_player_y,
  input  logic [DIR_W-1:0] i_player_dir,
  output logic             o_player_hit,
  output logic [RGB_W-1:0] o_player_rgb
);

  dir_t           dir;
  logic [X_W:0]   x_end;     // one extra bit so the box edge cannot wrap
  logic [Y_W:0]   y_end;
  logic [X_W-1:0] local_x;
  logic [Y_W-1:0] local_y;
  logic           stripe;

  assign dir = dir_t'(i_player_dir);

  assign x_end = {1'b0, i_player_x} + (X_W + 1)'(SPRITE_W);
  assign y_end = {1'b0, i_player_y} + (Y_W + 1)'(SPRITE_H);

  // half-open box anchored at the player position
  assign o_player_hit = (i_draw_x >= i_player_x) && ({1'b0, i_draw_x} < x_end) &&
                        (i_draw_y >= i_player_y) && ({1'b0, i_draw_y} < y_end);

  assign local_x = i_draw_x - i_player_x;
  assign local_y = i_draw_y - i_player_y;

  // ----------------------------------------------------------
  // facing stripe
  // ----------------------------------------------------------
  always_comb begin
    stripe = 1'b0;
    case (dir)
      DIR_UP:    stripe = (local_y <  Y_W'(MARKER_W));
      DIR_DOWN:  stripe = (local_y >= Y_W'(SPRITE_H - MARKER_W));
      DIR_LEFT:  stripe = (local_x <  X_W'(MARKER_W));
      DIR_RIGHT: stripe = (local_x >= X_W'(SPRITE_W - MARKER_W));
      default:   stripe = 1'b0;  // standing still
    endcase
  end

  assign o_player_rgb = stripe ? MARKER_RGB : PLAYER_RGB;

endmodule

/* src/map_locator.sv */
`timescale 1ns/10ps

module map_locator import arena_geom_pkg::*; (
  input  logic [X_W-1:0]        i_draw_x,
  input  logic [Y_W-1:0]        i_draw_y,
  output logic [MAP_ADDR_W-1:0] o_map_addr,
  map_pos_if.locator            pos
);

  logic [X_W-1:0]        map_x;   // map-relative coordinate
  logic [Y_W-1:0]        map_y;
  logic [ROW_W-1:0]      row;
  logic [COL_W-1:0]      col;
  logic [MAP_ADDR_W-1:0] addr_raw;
  logic                  in_map;

  assign map_x = i_draw_x - X_W'(HUD_SIDE);
  assign map_y = i_draw_y - Y_W'(HUD_TOP);

  // bottom edge of the map is the bottom of the screen
  assign in_map = (i_draw_x >= X_W'(HUD_SIDE))           &&
                  (i_draw_x <  X_W'(SCREEN_W - HUD_SIDE)) &&
                  (i_draw_y >= Y_W'(HUD_TOP))            &&
                  (i_draw_y <  Y_W'(SCREEN_H));

  // ----------------------------------------------------------
  // tile index and address
  // ----------------------------------------------------------
  assign col = map_x[BLK_W_LOG2 +: COL_W];
  assign row = map_y[BLK_H_LOG2 +: ROW_W];

  assign addr_raw = MAP_ADDR_W'(row * NUM_COL) + MAP_ADDR_W'(col);

  assign pos.in_map   = in_map;
  assign pos.map_addr = addr_raw;
  assign pos.blk_x    = map_x[BLK_W_LOG2-1:0];
  assign pos.blk_y    = map_y[BLK_H_LOG2-1:0];

  assign o_map_addr = in_map ? addr_raw : '0;  // memory sees 0 over the HUD

  // row and column decode must land inside the map whenever the region test passes
  always_comb begin
    if (in_map) begin
      a_addr_range: assert (addr_raw < MAP_ADDR_W'(MAP_DEPTH))
        else $error("map address %0d beyond map", addr_raw);
    end
  end

endmodule

/* src/frame_anim_ctrl.sv */
`timescale 1ns/10ps

module frame_anim_ctrl import arena_tile_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic i_tick,
  output logic o_bomb_red
);

  logic [BOMB_CNT_W-1:0]  bomb_cnt;
  logic [BOMB_CNT_W-1:0]  bomb_cnt_nxt;

  // bomb cycle wraps after the red phase
  always_comb begin
    if (bomb_cnt == BOMB_CNT_W'(BOMB_CYCLE_TICKS - 1)) begin
      bomb_cnt_nxt = '0;
    end else begin
      bomb_cnt_nxt = bomb_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // tick counter
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      bomb_cnt   <= '0;
      o_bomb_red <= 1'b0;
    end else if (i_tick) begin
      bomb_cnt <= bomb_cnt_nxt;
      // compare on the next count so the phase flips with the counter
      o_bomb_red <= (bomb_cnt_nxt >= BOMB_CNT_W'(BOMB_DARK_TICKS));
    end
  end

  // counter wraps before its limit
  a_cnt_range: assert property (
    @(posedge clk) disable iff (rst)
    bomb_cnt < BOMB_CNT_W'(BOMB_CYCLE_TICKS)
  ) else $error("animation counter out of range");

endmodule

/* src/map_pos_if.sv */
`timescale 1ns/10ps

interface map_pos_if import arena_geom_pkg::*; ();

  logic                  in_map;    // coordinate lies inside the tile area
  logic [MAP_ADDR_W-1:0] map_addr;  // row * NUM_COL + col
  logic [BLK_W_LOG2-1:0] blk_x;     // pixel offset inside the tile
  logic [BLK_H_LOG2-1:0] blk_y;

  modport locator (
    output in_map, map_addr, blk_x, blk_y
  );

  modport consumer (
    input in_map, map_addr, blk_x, blk_y
  );

endinterface

/* src/arena_tile_pkg.sv */
package arena_tile_pkg;

  localparam int STATE_W = 2;
  localparam int DIR_W   = 3;
  localparam int RGB_W   = 12;   // 4 bits per channel

  // tile state as returned by the map memory
  typedef enum logic [STATE_W-1:0] {
    NO_BLK,
    PERM_BLK,
    DESTROYABLE_BLK,
    BOMB
  } map_state_t;

  typedef enum logic [DIR_W-1:0] {
    DIR_NONE,
    DIR_UP,
    DIR_DOWN,
    DIR_LEFT,
    DIR_RIGHT
  } dir_t;

  // ----------------------------------------------------------
  // palette
  // ----------------------------------------------------------
  localparam logic [RGB_W-1:0] HUD_RGB      = 12'h223;
  localparam logic [RGB_W-1:0] BG_RGB       = 12'h173;
  localparam logic [RGB_W-1:0] PERM_RGB     = 12'h888;
  localparam logic [RGB_W-1:0] PERM_RIM_RGB = 12'hCCC;
  localparam logic [RGB_W-1:0] BRICK_RGB    = 12'hA52;
  localparam logic [RGB_W-1:0] BOMB_RGB     = 12'h111;
  localparam logic [RGB_W-1:0] BOMB_RED_RGB = 12'hF00;
  localparam logic [RGB_W-1:0] EXPL_RGB     = 12'hFA0;
  localparam logic [RGB_W-1:0] PLAYER_RGB   = 12'hFFF;
  localparam logic [RGB_W-1:0] MARKER_RGB   = 12'h00F;

  // ----------------------------------------------------------
  // shapes and animation timing
  // ----------------------------------------------------------
  localparam int RIM_W            = 4;
  localparam int BOMB_INSET       = 16;   // leaves a 32x32 square
  localparam int SPRITE_W         = 32;
  localparam int SPRITE_H         = 48;
  localparam int MARKER_W         = 4;
  localparam int FRAME_TICKS      = 60;
  localparam int BOMB_CYCLE_TICKS = 180;
  localparam int BOMB_DARK_TICKS  = 120;
  localparam int FRAME_CNT_W      = $clog2(FRAME_TICKS);
  localparam int BOMB_CNT_W       = $clog2(BOMB_CYCLE_TICKS);

endpackage

/* src/arena_geom_pkg.sv */
package arena_geom_pkg;

  // ----------------------------------------------------------
  // screen and HUD frame
  // ----------------------------------------------------------
  localparam int SCREEN_W = 1280;
  localparam int SCREEN_H = 800;
  localparam int HUD_SIDE = 32;   // left and right band
  localparam int HUD_TOP  = 96;   // score area above the map

  // ----------------------------------------------------------
  // tile map
  // ----------------------------------------------------------
  localparam int NUM_ROW    = 11;
  localparam int NUM_COL    = 19;
  localparam int MAP_DEPTH  = NUM_ROW * NUM_COL;
  localparam int MAP_ADDR_W = $clog2(MAP_DEPTH);
  localparam int ROW_W      = $clog2(NUM_ROW);
  localparam int COL_W      = $clog2(NUM_COL);

  // tiles are power-of-two squares so offsets are plain low bits
  localparam int BLK_W      = 64;
  localparam int BLK_H      = 64;
  localparam int BLK_W_LOG2 = $clog2(BLK_W);
  localparam int BLK_H_LOG2 = $clog2(BLK_H);

  // draw coordinate widths
  localparam int X_W = 11;
  localparam int Y_W = 10;

endpackage
